/* rtl/convPkg.sv */
package convPkg;

	// Pixel and stripe geometry
	localparam int PIXEL_BITS = 8;
	localparam int ROW_PIXELS = 8;
	localparam int KERNEL_SIZE = 3;

	// Window positions that fit inside one row word
	localparam int OUT_PIXELS = ROW_PIXELS - KERNEL_SIZE + 1;

	// Largest value an output pixel can hold
	localparam int PIXEL_MAX = (1 << PIXEL_BITS) - 1;

	// Arithmetic widths
	localparam int COEF_BITS = 16;
	localparam int ACC_BITS = 28;

	// Products, row sums, total, clamp
	localparam int LANE_LATENCY = 4;

	typedef logic [PIXEL_BITS-1:0] pixelT;

	// Pixel j sits in bits 8j upward
	typedef logic [ROW_PIXELS*PIXEL_BITS-1:0] rowWordT;

	// Output pixel c sits in bits 8c upward
	typedef logic [OUT_PIXELS*PIXEL_BITS-1:0] outWordT;

	typedef logic signed [COEF_BITS-1:0] coefT;

	// Nine 8x16 products plus growth of the sum
	typedef logic signed [ACC_BITS-1:0] accT;

	typedef logic [15:0] heightT;
	typedef logic [31:0] addrT;

	// Sharpening kernel
	// Row 0 is the oldest row of the window, column k covers pixel c+k
	localparam coefT KERNEL [KERNEL_SIZE][KERNEL_SIZE] = '{
		'{-16'sd1, -16'sd1, -16'sd1},
		'{-16'sd1,  16'sd9, -16'sd1},
		'{-16'sd1, -16'sd1, -16'sd1}
	};

endpackage

/* rtl/rowFetchCtrl.sv */
`timescale 1ns/100ps

module rowFetchCtrl (
	input logic clk,
	input logic reset,
	input logic i_start,
	input convPkg::heightT i_height,
	input logic i_valid,
	output logic o_req,
	output convPkg::addrT o_rdAddress,
	output logic o_shift,
	output logic o_outValid,
	output logic o_done
);

	import convPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT
	} stateT;

	stateT state;

	// Frame bookkeeping
	heightT frameHeight;
	heightT reqCount;
	heightT rxCount;
	logic lastRow;
	logic windowFull;

	// Tags for the row that just entered the window
	logic readyTag;
	logic doneTag;

	// Tags delayed to line up with the lane outputs
	logic [LANE_LATENCY-1:0] readyChain;
	logic [LANE_LATENCY-1:0] doneChain;

	// One request per REQUEST cycle, address is the row index
	assign o_req = (state == REQUEST);
	assign o_rdAddress = addrT'(reqCount);

	// Row moves into the window in the cycle it arrives
	assign o_shift = i_valid && (state == WAIT);

	// rxCount still holds the count before this row
	assign lastRow = (rxCount == frameHeight - 1'b1);
	assign windowFull = (rxCount >= heightT'(KERNEL_SIZE - 1));

	// Frame FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			frameHeight <= '0;
			reqCount <= '0;
			rxCount <= '0;
		end
		else begin
			case (state)
				IDLE: begin
					// Start is only looked at between frames
					if (i_start) begin
						frameHeight <= i_height;
						reqCount <= '0;
						rxCount <= '0;
						state <= REQUEST;
					end
				end
				REQUEST: begin
					reqCount <= reqCount + 1'b1;
					state <= WAIT;
				end
				WAIT: begin
					if (i_valid) begin
						rxCount <= rxCount + 1'b1;
						// Next request one cycle after the answer
						if (reqCount < frameHeight) begin
							state <= REQUEST;
						end
						else begin
							state <= IDLE;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Tag pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			readyTag <= 1'b0;
			doneTag <= 1'b0;
			readyChain <= '0;
			doneChain <= '0;
		end
		else begin
			// Window is complete from the third row onward
			readyTag <= o_shift && windowFull;
			doneTag <= o_shift && lastRow;

			readyChain <= {readyChain[LANE_LATENCY-2:0], readyTag};
			doneChain <= {doneChain[LANE_LATENCY-2:0], doneTag};
		end
	end

	assign o_outValid = readyChain[LANE_LATENCY-1];
	assign o_done = doneChain[LANE_LATENCY-1];

endmodule

/* rtl/rowWindow.sv */
`timescale 1ns/100ps

module rowWindow (
	input logic clk,
	input logic reset,
	input logic i_shift,
	input convPkg::rowWordT i_row,
	output convPkg::rowWordT o_rows [convPkg::KERNEL_SIZE]
);

	import convPkg::*;

	// Row 0 is the oldest, the last row is the newest
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				o_rows[r] <= '0;
			end
		end
		else if (i_shift) begin
			// Oldest row falls out
			for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
				o_rows[r] <= o_rows[r+1];
			end
			o_rows[KERNEL_SIZE-1] <= i_row;
		end
	end

endmodule

/* rtl/convLane.sv */
`timescale 1ns/100ps

module convLane #(
	parameter int LANE = 0
) (
	input logic clk,
	input logic reset,
	input convPkg::rowWordT i_rows [convPkg::KERNEL_SIZE],
	output convPkg::pixelT o_pixel
);

	import convPkg::*;

	// Lane must start a block that fits inside the row word
	if (LANE < 0 || LANE >= OUT_PIXELS) begin : laneRangeCheck
		$error("convLane: LANE out of range");
	end

	// Stage 1, one product per window pixel
	accT products [KERNEL_SIZE][KERNEL_SIZE];

	// Stage 2, one sum per window row
	accT rowSums [KERNEL_SIZE];

	// Stage 3, full kernel sum
	accT total;

	// Pixel at window row r, column k of this lane
	function automatic pixelT windowPixel(input rowWordT row, input int k);
		pixelT pix;
		pix = row[(LANE + k) * PIXEL_BITS +: PIXEL_BITS];
		return pix;
	endfunction

	// Multipliers, pixel zero-extended before the signed multiply
	always_ff @(posedge clk) begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int k = 0; k < KERNEL_SIZE; k++) begin
				products[r][k] <= accT'(windowPixel(i_rows[r], k)) * accT'(KERNEL[r][k]);
			end
		end
	end

	// First adder level
	always_ff @(posedge clk) begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			rowSums[r] <= products[r][0] + products[r][1] + products[r][2];
		end
	end

	// Second adder level
	always_ff @(posedge clk) begin
		total <= rowSums[0] + rowSums[1] + rowSums[2];
	end

	// Clamp to the pixel range
	always_ff @(posedge clk) begin
		if (reset) begin
			o_pixel <= '0;
		end
		else if (total < 0) begin
			o_pixel <= '0;
		end
		else if (total > accT'(PIXEL_MAX)) begin
			o_pixel <= pixelT'(PIXEL_MAX);
		end
		else begin
			o_pixel <= total[PIXEL_BITS-1:0];
		end
	end

endmodule

/* rtl/convEngine.sv */
`timescale 1ns/100ps

module convEngine (
	input logic clk,
	input logic reset,
	input logic i_start,
	input convPkg::heightT i_height,
	input logic i_valid,
	input convPkg::rowWordT i_data,
	output logic o_req,
	output convPkg::addrT o_rdAddress,
	output logic o_valid,
	output convPkg::outWordT o_data,
	output logic o_done
);

	import convPkg::*;

	logic shift;

	// Oldest row first
	rowWordT windowRows [KERNEL_SIZE];

	// One result per window position
	pixelT lanePixels [OUT_PIXELS];

	rowFetchCtrl fetchCtrl_i (
		.clk(clk),
		.reset(reset),
		.i_start(i_start),
		.i_height(i_height),
		.i_valid(i_valid),
		.o_req(o_req),
		.o_rdAddress(o_rdAddress),
		.o_shift(shift),
		.o_outValid(o_valid),
		.o_done(o_done)
	);

	// Incoming row goes straight into the window
	rowWindow window_i (
		.clk(clk),
		.reset(reset),
		.i_shift(shift),
		.i_row(i_data),
		.o_rows(windowRows)
	);

	// Six lanes share the window, each takes its own column slice
	for (genvar c = 0; c < OUT_PIXELS; c++) begin : lanes
		convLane #(
			.LANE(c)
		) lane_i (
			.clk(clk),
			.reset(reset),
			.i_rows(windowRows),
			.o_pixel(lanePixels[c])
		);

		assign o_data[c*PIXEL_BITS +: PIXEL_BITS] = lanePixels[c];
	end

endmodule

/* test/convEngine_checker.sv */
`timescale 1ns/100ps

module convEngine_checker (
	input logic clk,
	input logic reset,
	input logic i_start,
	input logic i_valid,
	input logic o_req,
	input convPkg::addrT o_rdAddress,
	input logic o_outValid,
	input logic o_done,
	input convPkg::heightT i_frameHeight
);

	import convPkg::*;

	logic pending;
	logic started;
	addrT nextAddr;

	// Outstanding request and the address the next one must carry
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			started <= 1'b0;
			nextAddr <= '0;
		end
		else begin
			if (i_start) begin
				started <= 1'b1;
				nextAddr <= '0;
			end
			if (o_req) begin
				pending <= 1'b1;
				nextAddr <= o_rdAddress + addrT'(1);
			end
			else if (i_valid) begin
				pending <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) o_req |-> !pending)
		else $error("Row request issued while another one is outstanding");

	assert property (@(posedge clk) disable iff (reset) o_req |-> o_rdAddress == nextAddr)
		else $error("Row address out of sequence");

	assert property (@(posedge clk) disable iff (reset)
		o_req |-> o_rdAddress < addrT'(i_frameHeight))
		else $error("Row request beyond the frame height");

	// Quiet outputs until the first frame starts
	assert property (@(posedge clk) disable iff (reset)
		!started |-> !o_req && !o_outValid && !o_done)
		else $error("Controller output active before the first start");

	assert property (@(posedge clk) disable iff (reset) o_done |-> o_outValid)
		else $error("Done tag without a valid output");

endmodule

bind rowFetchCtrl convEngine_checker checker_i (.*, .i_frameHeight(frameHeight));

/* test/convEngineMonitor.sv */
`timescale 1ns/100ps

module convEngineMonitor (
	input logic clk,
	input logic reset,
	input logic i_start,
	input convPkg::heightT i_height,
	input logic i_valid,
	input convPkg::rowWordT i_data,
	input logic o_valid,
	input convPkg::outWordT o_data,
	input logic o_done,
	output int o_checks,
	output int o_errors,
	output int o_frames
);

	import convPkg::*;

	// Oldest row first
	rowWordT rows [KERNEL_SIZE];
	int cycle;
	int rxRows;
	int frameHeight;
	int frameOutputs;
	int frameStartErrors;
	outWordT expWord;
	int dueCycle;
	logic dueDone;

	// Expected outputs in arrival order
	outWordT expData [$];
	int expCycle [$];
	logic expDone [$];

	// Clamped sharpening result at every window position
	function automatic outWordT kernelResult(input rowWordT r0, input rowWordT r1,
			input rowWordT r2);
		rowWordT win [KERNEL_SIZE];
		pixelT pix;
		int sum;
		outWordT res;
		win[0] = r0;
		win[1] = r1;
		win[2] = r2;
		res = '0;
		for (int c = 0; c < OUT_PIXELS; c++) begin
			sum = 0;
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				for (int k = 0; k < KERNEL_SIZE; k++) begin
					pix = win[r][(c + k) * PIXEL_BITS +: PIXEL_BITS];
					sum += int'(KERNEL[r][k]) * int'(pix);
				end
			end
			if (sum < 0) begin
				sum = 0;
			end
			else if (sum > PIXEL_MAX) begin
				sum = PIXEL_MAX;
			end
			res[c * PIXEL_BITS +: PIXEL_BITS] = pixelT'(sum);
		end
		return res;
	endfunction

	always @(negedge clk) begin
		if (reset) begin
			cycle = 0;
			rxRows = 0;
			frameHeight = 0;
			frameOutputs = 0;
			frameStartErrors = 0;
			o_checks = 0;
			o_errors = 0;
			o_frames = 0;
			rows = '{default: '0};
			expData.delete();
			expCycle.delete();
			expDone.delete();
		end
		else begin
			cycle++;
			if (i_start) begin
				frameHeight = int'(i_height);
				rxRows = 0;
				frameOutputs = 0;
				frameStartErrors = o_errors;
			end
			if (i_valid) begin
				rows[0] = rows[1];
				rows[1] = rows[2];
				rows[2] = i_data;
				rxRows++;
				if (rxRows >= KERNEL_SIZE) begin
					expData.push_back(kernelResult(rows[0], rows[1], rows[2]));
					// Window update plus the lane pipeline
					expCycle.push_back(cycle + 1 + LANE_LATENCY);
					expDone.push_back(rxRows == frameHeight);
				end
			end
			if (o_valid) begin
				frameOutputs++;
				if (expData.size() == 0) begin
					$display("Unexpected output word at %0t with nothing pending", $time);
					o_errors++;
				end
				else begin
					expWord = expData.pop_front();
					dueCycle = expCycle.pop_front();
					dueDone = expDone.pop_front();
					o_checks++;
					if (o_data !== expWord) begin
						$display("Mismatch at %0t: o_data %h, expected %h", $time, o_data, expWord);
						o_errors++;
					end
					if (cycle != dueCycle) begin
						$display("Mismatch at %0t: output in cycle %0d, expected cycle %0d",
							$time, cycle, dueCycle);
						o_errors++;
					end
					if (o_done !== dueDone) begin
						$display("Mismatch at %0t: o_done %b, expected %b", $time, o_done, dueDone);
						o_errors++;
					end
				end
			end
			else if (o_done) begin
				$display("Done pulse at %0t without a valid output", $time);
				o_errors++;
			end
			if (o_done) begin
				if (frameOutputs != frameHeight - 2) begin
					$display("Frame %0d produced %0d outputs instead of %0d",
						o_frames, frameOutputs, frameHeight - 2);
					o_errors++;
				end
				$display("Frame %0d: height %0d, %0d outputs, %0s", o_frames, frameHeight,
					frameOutputs, (o_errors == frameStartErrors) ? "ok" : "errors");
				o_frames++;
			end
		end
	end

endmodule

/* test/convEngineTb.sv */
`timescale 1ns/100ps

module convEngineTb;

	import convPkg::*;

	localparam int FRAMES = 6;
	localparam int MIN_HEIGHT = 3;
	localparam int MAX_HEIGHT = 12;

	logic clk;
	logic reset;
	logic i_start;
	heightT i_height;
	logic i_valid;
	rowWordT i_data;
	logic o_req;
	addrT o_rdAddress;
	logic o_valid;
	outWordT o_data;
	logic o_done;

	int checks;
	int errors;
	int frames;
	int totalRows;
	int timeoutCycles = 0;
	int delay;
	logic [3:0] rowIndex;

	// Image of the frame in flight, one word per row
	rowWordT image [16];
	heightT heights [FRAMES];

	convEngine convEngine_i (.*);

	convEngineMonitor monitor_i (.*, .o_checks(checks), .o_errors(errors), .o_frames(frames));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ten cycles per row is far more than the slowest memory needs
	initial begin
		wait (timeoutCycles > 0);
		repeat (timeoutCycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
		$display("Testbench failed");
		$finish;
	end

	// Memory answers each request after 1 to 4 cycles
	initial begin
		i_valid = 1'b0;
		i_data = '0;
		forever begin
			@(negedge clk);
			if (o_req === 1'b1) begin
				rowIndex = o_rdAddress[3:0];
				delay = 1 + int'($urandom_range(3));
				repeat (delay) @(posedge clk);
				#1;
				i_valid = 1'b1;
				i_data = image[rowIndex];
				@(posedge clk);
				#1;
				i_valid = 1'b0;
				i_data = '0;
			end
		end
	end

	initial begin
		void'($urandom(32'he76c));
		reset = 1'b1;
		i_start = 1'b0;
		i_height = '0;
		totalRows = 0;
		for (int f = 0; f < FRAMES; f++) begin
			heights[f] = heightT'(MIN_HEIGHT + $urandom_range(MAX_HEIGHT - MIN_HEIGHT));
			totalRows += int'(heights[f]);
		end
		timeoutCycles = totalRows * 10 + 200;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		// Idle stretch before the first start
		repeat (5) @(posedge clk);
		for (int f = 0; f < FRAMES; f++) begin
			for (int r = 0; r < MAX_HEIGHT; r++) begin
				image[r] = {$urandom, $urandom};
			end
			@(posedge clk);
			#1;
			i_start = 1'b1;
			i_height = heights[f];
			@(posedge clk);
			#1;
			i_start = 1'b0;
			do @(negedge clk); while (o_done !== 1'b1);
			repeat (3) @(posedge clk);
		end
		$display("Frames %0d, outputs checked %0d, errors %0d", frames, checks, errors);
		if (errors == 0 && frames == FRAMES) begin
			$display("Testbench passed");
		end
		else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* convEngine.f */
rtl/convPkg.sv
rtl/rowFetchCtrl.sv
rtl/rowWindow.sv
rtl/convLane.sv
rtl/convEngine.sv
test/convEngine_checker.sv
test/convEngineMonitor.sv
test/convEngineTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the convEngine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module convEngineTb -f convEngine.f -o convEngineSim
output=$(./obj_dir/convEngineSim) || true
echo "$output"
if echo "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
